// ==== hw/ebox_macros.svh ====
// EBOX control slice widths and counts shared by every block
`ifndef EBOX_MACROS_SVH
`define EBOX_MACROS_SVH

// Full machine word
`define WORD_W 36

// One register half, left or right
`define HALF_W 18

// Console diagnostic function code
`define DS_W 7

// ARL, ARR, ARXL, ARXR
`define NUM_HALVES 4

`endif

// ==== hw/ebox_pkg.sv ====
// EBOX control types: microword fields, half source select and inter-block structs
`include "ebox_macros.svh"

package ebox_pkg;

  // Dispatch field
  typedef enum logic [2:0] {
    dispNone      = 3'd0,
    dispDramARead = 3'd1,
    dispRet       = 3'd2,
    dispNiCond    = 3'd3,
    dispMul       = 3'd4,
    dispDiv       = 3'd5,
    dispNorm      = 3'd6,
    dispEaMod     = 3'd7
  } dispE;

  // Special function field
  typedef enum logic [3:0] {
    specNone    = 4'd0,
    specLoadPc  = 4'd1,
    specArlInd  = 4'd2,
    specAdLong  = 4'd3,
    specMqShift = 4'd4,
    specSbrCall = 4'd5
  } specE;

  // Conditional function field, only live with condEn
  typedef enum logic [2:0] {
    condNone     = 3'd0,
    condArllLoad = 3'd1,
    condArlrLoad = 3'd2,
    condArrLoad  = 3'd3,
    condArClr    = 3'd4,
    condArxClr   = 3'd5,
    condArlInd   = 3'd6,
    condRegCtl   = 3'd7
  } condE;

  // Source of a register half on load
  typedef enum logic [1:0] {
    holdSel = 2'd0,
    adSel   = 2'd1,
    ebusSel = 2'd2,
    swapSel = 2'd3
  } halfSelE;

  // One microword as seen by the control slice
  typedef struct packed {
    dispE       disp;
    specE       spec;
    condE       cond;
    logic       condEn;
    logic [2:0] arField;
    logic [2:0] arxField;
    logic [8:0] magic;
  } cramWordT;

  // Control for one register half
  typedef struct packed {
    logic    load;
    logic    clr;
    halfSelE sel;
  } halfCtlT;

  // Console request, strobe lasts one cycle
  typedef struct packed {
    logic             strobe;
    logic [`DS_W-1:0] ds;
  } diagReqT;

endpackage

// ==== hw/ctlDecode.sv ====
// Microword and console function decoder producing the per-half register controls
`timescale 1ns/1ps
`include "ebox_macros.svh"

module ctlDecode (
  input  logic                                   CTL,
  input  logic                                   rst,
  input  ebox_pkg::cramWordT                     cram,
  input  logic                                   sbrCall,
  input  ebox_pkg::diagReqT                      diagReq,
  input  logic [`WORD_W-1:0]                     ebusData,
  output ebox_pkg::halfCtlT [`NUM_HALVES-1:0]    halfCtl,
  output logic [2:0]                             readSel,
  output logic                                   readEn,
  output logic [4:0]                             diagCtlReg,
  output logic                                   loadPc,
  output logic                                   adLong
);

  ebox_pkg::halfCtlT [`NUM_HALVES-1:0] ucodeCtl;
  logic                                indMode;
  logic                                condArClr;
  logic                                condArxClr;
  logic                                consoleLoad;
  logic [1:0]                          consoleIdx;
  logic                                ctlRegLoad;

  // Shared coding of arField and arxField
  function automatic ebox_pkg::halfCtlT fieldCtl(input logic [2:0] field);
    ebox_pkg::halfCtlT c;
    c = '{load: 1'b0, clr: 1'b0, sel: ebox_pkg::holdSel};
    case (field)
      3'd1: c = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::adSel};
      3'd2: c = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::ebusSel};
      3'd3: c = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::swapSel};
      default: ;
    endcase
    return c;
  endfunction

  assign adLong = cram.disp inside {ebox_pkg::dispMul, ebox_pkg::dispDiv, ebox_pkg::dispNorm}
                  || cram.spec inside {ebox_pkg::specAdLong, ebox_pkg::specMqShift};

  assign loadPc = (cram.spec == ebox_pkg::specLoadPc || cram.disp == ebox_pkg::dispNiCond)
                  && !sbrCall;

  // Indirect through magic, entered from either field
  assign indMode = (cram.condEn && cram.cond == ebox_pkg::condArlInd)
                   || cram.spec == ebox_pkg::specArlInd;

  assign condArClr  = cram.condEn && cram.cond == ebox_pkg::condArClr;
  assign condArxClr = cram.condEn && cram.cond == ebox_pkg::condArxClr;

  always_comb begin
    ucodeCtl[0] = fieldCtl(cram.arField);
    ucodeCtl[1] = fieldCtl(cram.arField);
    ucodeCtl[2] = fieldCtl(cram.arxField);
    ucodeCtl[3] = fieldCtl(cram.arxField);

    if (cram.disp == ebox_pkg::dispDramARead) begin
      ucodeCtl[0] = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::adSel};
      ucodeCtl[1] = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::adSel};
    end

    // Single-half loads
    if (cram.condEn) begin
      case (cram.cond)
        ebox_pkg::condArllLoad: ucodeCtl[0] = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::adSel};
        ebox_pkg::condArlrLoad: ucodeCtl[1] = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::adSel};
        ebox_pkg::condArrLoad:  ucodeCtl[1] = '{load: 1'b1, clr: 1'b0, sel: ebox_pkg::ebusSel};
        default: ;
      endcase
    end

    if (indMode) begin
      if (cram.magic[6]) begin
        ucodeCtl[0].sel = ebox_pkg::adSel;
      end
      if (cram.magic[7]) begin
        ucodeCtl[1].sel = ebox_pkg::adSel;
      end
      ucodeCtl[0].clr = cram.magic[4];
      ucodeCtl[1].clr = cram.magic[5];
      ucodeCtl[2].clr = cram.magic[3];
      ucodeCtl[3].clr = cram.magic[3];
    end else begin
      ucodeCtl[0].clr = condArClr;
      ucodeCtl[1].clr = condArClr;
      ucodeCtl[2].clr = condArxClr;
      ucodeCtl[3].clr = condArxClr;
    end
  end

  // Console function decode
  always_comb begin
    consoleLoad = 1'b0;
    ctlRegLoad  = 1'b0;
    readEn      = 1'b0;
    consoleIdx  = diagReq.ds[1:0];
    readSel     = diagReq.ds[2:0];
    if (diagReq.strobe) begin
      case (diagReq.ds)
        7'o070, 7'o071, 7'o072, 7'o073: consoleLoad = 1'b1;
        7'o076: ctlRegLoad = 1'b1;
        7'o100, 7'o101, 7'o102, 7'o103, 7'o104: readEn = 1'b1;
        default: ;
      endcase
    end
  end

  // Console loads take the half from the microword; reset clears everything
  always_comb begin
    halfCtl = ucodeCtl;
    for (int i = 0; i < `NUM_HALVES; i++) begin
      if (consoleLoad && consoleIdx == 2'(i)) begin
        halfCtl[i].load = 1'b1;
        halfCtl[i].sel  = ebox_pkg::ebusSel;
      end
      if (rst) begin
        halfCtl[i].clr = 1'b1;
      end
    end
  end

  always_ff @(posedge CTL) begin
    if (rst) begin
      diagCtlReg <= '0;
    end else if (ctlRegLoad) begin
      diagCtlReg <= ebusData[28:24];
    end
  end

endmodule

// ==== hw/regHalf.sv ====
// One 18-bit register half with clear, source select and hold
`timescale 1ns/1ps
`include "ebox_macros.svh"

module regHalf (
  input  logic                CTL,
  input  ebox_pkg::halfCtlT   ctl,
  input  logic [`HALF_W-1:0]  adHalf,
  input  logic [`HALF_W-1:0]  ebusHalf,
  input  logic [`HALF_W-1:0]  otherHalf,
  output logic [`HALF_W-1:0]  q
);

  logic [`HALF_W-1:0] srcData;

  always_comb begin
    case (ctl.sel)
      ebox_pkg::adSel:   srcData = adHalf;
      ebox_pkg::ebusSel: srcData = ebusHalf;
      // Partner half, so AR can swap in one cycle
      ebox_pkg::swapSel: srcData = otherHalf;
      default:           srcData = q;
    endcase
  end

  // Clear wins over load
  always_ff @(posedge CTL) begin
    if (ctl.clr) begin
      q <= '0;
    end else if (ctl.load) begin
      q <= srcData;
    end
  end

endmodule

// ==== hw/diagReadMux.sv ====
// Console read port, registers one half or the diagnostic control register
`timescale 1ns/1ps
`include "ebox_macros.svh"

module diagReadMux (
  input  logic                                  CTL,
  input  logic                                  rst,
  input  logic [`NUM_HALVES-1:0][`HALF_W-1:0]   halfBus,
  input  logic [4:0]                            diagCtlReg,
  input  logic [2:0]                            readSel,
  input  logic                                  readEn,
  output logic [`WORD_W-1:0]                    diagRead,
  output logic                                  diagReadValid
);

  logic [`WORD_W-1:0] readWord;

  always_comb begin
    readWord = '0;
    if (readSel == 3'd4) begin
      // Same bit position it is loaded from
      readWord[28:24] = diagCtlReg;
    end else if (!readSel[2]) begin
      readWord[`HALF_W-1:0] = halfBus[readSel[1:0]];
    end
  end

  // Captures the value from before this edge's update
  always_ff @(posedge CTL) begin
    if (rst) begin
      diagRead      <= '0;
      diagReadValid <= 1'b0;
    end else begin
      diagReadValid <= readEn;
      diagRead      <= readEn ? readWord : '0;
    end
  end

endmodule

// ==== hw/eboxCtlTop.sv ====
// EBOX control slice top: decoder, AR and ARX register halves and console read port
`timescale 1ns/1ps
`include "ebox_macros.svh"

module eboxCtlTop (
  input  logic                CTL,
  input  logic                rst,
  input  ebox_pkg::cramWordT  cram,
  input  logic                sbrCall,
  input  logic [`WORD_W-1:0]  ad,
  input  logic [`WORD_W-1:0]  ebusData,
  input  ebox_pkg::diagReqT   diagReq,
  output logic [`WORD_W-1:0]  ar,
  output logic [`WORD_W-1:0]  arx,
  output logic                loadPc,
  output logic                adLong,
  output logic [`WORD_W-1:0]  diagRead,
  output logic                diagReadValid
);

  ebox_pkg::halfCtlT [`NUM_HALVES-1:0]  halfCtl;
  logic [`NUM_HALVES-1:0][`HALF_W-1:0]  halfBus;
  logic [2:0]                           readSel;
  logic                                 readEn;
  logic [4:0]                           diagCtlReg;

  ctlDecode uDecode (
    .CTL        (CTL),
    .rst        (rst),
    .cram       (cram),
    .sbrCall    (sbrCall),
    .diagReq    (diagReq),
    .ebusData   (ebusData),
    .halfCtl    (halfCtl),
    .readSel    (readSel),
    .readEn     (readEn),
    .diagCtlReg (diagCtlReg),
    .loadPc     (loadPc),
    .adLong     (adLong)
  );

  // Even index is a left half, odd a right half
  for (genvar gi = 0; gi < `NUM_HALVES; gi++) begin : genHalf
    regHalf uHalf (
      .CTL       (CTL),
      .ctl       (halfCtl[gi]),
      .adHalf    (ad[`HALF_W*(1-(gi%2)) +: `HALF_W]),
      .ebusHalf  (ebusData[`HALF_W*(1-(gi%2)) +: `HALF_W]),
      .otherHalf (halfBus[gi^1]),
      .q         (halfBus[gi])
    );
  end

  diagReadMux uRead (
    .CTL           (CTL),
    .rst           (rst),
    .halfBus       (halfBus),
    .diagCtlReg    (diagCtlReg),
    .readSel       (readSel),
    .readEn        (readEn),
    .diagRead      (diagRead),
    .diagReadValid (diagReadValid)
  );

  assign ar  = {halfBus[0], halfBus[1]};
  assign arx = {halfBus[2], halfBus[3]};

endmodule

// ==== sim/clkGen.sv ====
// Testbench clock and reset source, 10 ns CTL period and 10 cycles of reset
`timescale 1ns/1ps

module clkGen (
  output logic CTL,
  output logic rst
);

  initial begin
    CTL = 1'b0;
    forever begin
      #5 CTL = ~CTL;
    end
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge CTL);
    @(negedge CTL);
    rst = 1'b0;
  end

endmodule

// ==== sim/eboxCtlTb.sv ====
// EBOX control slice testbench with random stimulus, reference model and assertion checks
`timescale 1ns/1ps
`include "ebox_macros.svh"

module eboxCtlTb;

  // Reset, reads after reset, four random phases and a short tail
  localparam int totalCycles = 10 + 2 + 8 + 200 + 200 + 150 + 250 + 4;
  localparam logic [6:0] consoleCodes [10] = '{7'o070, 7'o071, 7'o072, 7'o073, 7'o076,
                                               7'o100, 7'o101, 7'o102, 7'o103, 7'o104};

  logic                CTL;
  logic                rst;
  ebox_pkg::cramWordT  cram;
  logic                sbrCall;
  logic [`WORD_W-1:0]  ad;
  logic [`WORD_W-1:0]  ebusData;
  ebox_pkg::diagReqT   diagReq;
  logic [`WORD_W-1:0]  ar;
  logic [`WORD_W-1:0]  arx;
  logic                loadPc;
  logic                adLong;
  logic [`WORD_W-1:0]  diagRead;
  logic                diagReadValid;

  logic [`HALF_W-1:0]  mHalf [4];
  logic [4:0]          mCtlReg;
  logic [`WORD_W-1:0]  mRead;
  logic                mValid;
  logic [`WORD_W-1:0]  expAr;
  logic [`WORD_W-1:0]  expArx;
  logic                expLoadPc;
  logic                expAdLong;
  int                  errCount;

  clkGen uClk (
    .CTL (CTL),
    .rst (rst)
  );

  eboxCtlTop UUT (
    .CTL           (CTL),
    .rst           (rst),
    .cram          (cram),
    .sbrCall       (sbrCall),
    .ad            (ad),
    .ebusData      (ebusData),
    .diagReq       (diagReq),
    .ar            (ar),
    .arx           (arx),
    .loadPc        (loadPc),
    .adLong        (adLong),
    .diagRead      (diagRead),
    .diagReadValid (diagReadValid)
  );

  function automatic logic [`HALF_W-1:0] halfOf(input logic [`WORD_W-1:0] w, input int i);
    return (i % 2 == 0) ? w[35:18] : w[17:0];
  endfunction

  function automatic ebox_pkg::halfSelE fieldSrc(input logic [2:0] fld);
    case (fld)
      3'd1: return ebox_pkg::adSel;
      3'd2: return ebox_pkg::ebusSel;
      3'd3: return ebox_pkg::swapSel;
      default: return ebox_pkg::holdSel;
    endcase
  endfunction

  function automatic logic [`WORD_W-1:0] rand36();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[35:0];
  endfunction

  // Mode 0 register fields only, 1 adds cond and indirect, 2 adds disp and spec
  function automatic ebox_pkg::cramWordT randomWord(input int mode);
    ebox_pkg::cramWordT c;
    logic [31:0] r;
    logic [31:0] s;
    r = $urandom();
    s = $urandom();
    c = '0;
    c.arField = r[2:0];
    c.arxField = r[5:3];
    if (mode >= 1) begin
      c.cond = ebox_pkg::condE'(r[8:6]);
      c.condEn = r[9];
      c.magic = r[18:10];
      c.spec = r[19] ? ebox_pkg::specArlInd : ebox_pkg::specNone;
    end
    if (mode >= 2) begin
      c.disp = ebox_pkg::dispE'(r[22:20]);
      c.spec = ebox_pkg::specE'(4'(s % 6));
    end
    return c;
  endfunction

  function automatic ebox_pkg::diagReqT randomReq();
    ebox_pkg::diagReqT q;
    logic [31:0] r;
    r = $urandom();
    q.strobe = r[0];
    q.ds = consoleCodes[r[8:1] % 10];
    return q;
  endfunction

  task automatic driveCycle(input ebox_pkg::cramWordT c, input ebox_pkg::diagReqT q,
                            input logic sbr);
    @(negedge CTL);
    cram <= c;
    diagReq <= q;
    sbrCall <= sbr;
    ad <= rand36();
    ebusData <= rand36();
  endtask

  // Decoded outputs straight from the microword
  always_comb begin
    expAdLong = (cram.disp == ebox_pkg::dispMul) || (cram.disp == ebox_pkg::dispDiv)
                || (cram.disp == ebox_pkg::dispNorm) || (cram.spec == ebox_pkg::specAdLong)
                || (cram.spec == ebox_pkg::specMqShift);
    expLoadPc = !sbrCall && ((cram.spec == ebox_pkg::specLoadPc)
                             || (cram.disp == ebox_pkg::dispNiCond));
  end

  assign expAr  = {mHalf[0], mHalf[1]};
  assign expArx = {mHalf[2], mHalf[3]};

  // Reference model of the four halves, diagCtlReg and the read port
  always @(posedge CTL) begin : refModel
    ebox_pkg::halfSelE src [4];
    logic [3:0] ld;
    logic [3:0] cl;
    logic ind;
    int idx;
    ld = '0;
    cl = '0;
    for (int i = 0; i < 4; i++) begin
      src[i] = fieldSrc((i < 2) ? cram.arField : cram.arxField);
      ld[i] = (src[i] != ebox_pkg::holdSel);
    end
    if (cram.disp == ebox_pkg::dispDramARead) begin
      ld[1:0] = 2'b11;
      src[0] = ebox_pkg::adSel;
      src[1] = ebox_pkg::adSel;
    end
    if (cram.condEn && cram.cond == ebox_pkg::condArllLoad) begin
      ld[0] = 1'b1;
      src[0] = ebox_pkg::adSel;
    end
    if (cram.condEn && cram.cond == ebox_pkg::condArlrLoad) begin
      ld[1] = 1'b1;
      src[1] = ebox_pkg::adSel;
    end
    if (cram.condEn && cram.cond == ebox_pkg::condArrLoad) begin
      ld[1] = 1'b1;
      src[1] = ebox_pkg::ebusSel;
    end
    ind = (cram.condEn && cram.cond == ebox_pkg::condArlInd)
          || cram.spec == ebox_pkg::specArlInd;
    if (ind) begin
      if (cram.magic[6]) begin
        src[0] = ebox_pkg::adSel;
      end
      if (cram.magic[7]) begin
        src[1] = ebox_pkg::adSel;
      end
      cl = {cram.magic[3], cram.magic[3], cram.magic[5], cram.magic[4]};
    end else begin
      cl[1:0] = {2{cram.condEn && cram.cond == ebox_pkg::condArClr}};
      cl[3:2] = {2{cram.condEn && cram.cond == ebox_pkg::condArxClr}};
    end
    if (diagReq.strobe && diagReq.ds >= 7'o070 && diagReq.ds <= 7'o073) begin
      idx = int'(diagReq.ds[1:0]);
      ld[idx] = 1'b1;
      src[idx] = ebox_pkg::ebusSel;
    end
    if (rst) begin
      cl = 4'hf;
    end
    for (int i = 0; i < 4; i++) begin
      if (cl[i]) begin
        mHalf[i] <= '0;
      end else if (ld[i]) begin
        case (src[i])
          ebox_pkg::adSel:   mHalf[i] <= halfOf(ad, i);
          ebox_pkg::ebusSel: mHalf[i] <= halfOf(ebusData, i);
          ebox_pkg::swapSel: mHalf[i] <= mHalf[i ^ 1];
          default: ;
        endcase
      end
    end
    if (rst) begin
      mCtlReg <= '0;
      mRead <= '0;
      mValid <= 1'b0;
    end else begin
      if (diagReq.strobe && diagReq.ds == 7'o076) begin
        mCtlReg <= ebusData[28:24];
      end
      mValid <= diagReq.strobe && diagReq.ds >= 7'o100 && diagReq.ds <= 7'o104;
      if (!(diagReq.strobe && diagReq.ds >= 7'o100 && diagReq.ds <= 7'o104)) begin
        mRead <= '0;
      end else if (diagReq.ds == 7'o104) begin
        mRead <= {7'b0, mCtlReg, 24'b0};
      end else begin
        mRead <= {18'b0, mHalf[diagReq.ds[1:0]]};
      end
    end
  end

  arMatch: assert property (@(posedge CTL) disable iff (rst) ar == expAr)
    else begin
      errCount++;
      $display("Mismatch at %0t: ar is %h, expected %h", $time, $sampled(ar), $sampled(expAr));
    end

  arxMatch: assert property (@(posedge CTL) disable iff (rst) arx == expArx)
    else begin
      errCount++;
      $display("Mismatch at %0t: arx is %h, expected %h", $time, $sampled(arx),
               $sampled(expArx));
    end

  decodeMatch: assert property (@(posedge CTL) disable iff (rst)
                                loadPc == expLoadPc && adLong == expAdLong)
    else begin
      errCount++;
      $display("Mismatch at %0t: loadPc/adLong are %b/%b, expected %b/%b", $time,
               $sampled(loadPc), $sampled(adLong), $sampled(expLoadPc), $sampled(expAdLong));
    end

  readMatch: assert property (@(posedge CTL) disable iff (rst)
                              diagReadValid == mValid && diagRead == mRead)
    else begin
      errCount++;
      $display("Mismatch at %0t: read port is %b %h, expected %b %h", $time,
               $sampled(diagReadValid), $sampled(diagRead), $sampled(mValid), $sampled(mRead));
    end

  initial begin : watchdog
    // 1.5 times the stimulus length at 10 ns per cycle
    #(totalCycles * 15);
    $display("Timeout: the run did not end within the expected time");
    $display("Something failed");
    $finish;
  end

  initial begin : stimulus
    errCount = 0;
    cram = '0;
    sbrCall = 1'b0;
    ad = '0;
    ebusData = '0;
    diagReq = '0;
    void'($urandom(32'h9e83));
    wait (!rst);
    // Read diagCtlReg and every half straight after reset
    driveCycle('0, '{strobe: 1'b1, ds: 7'o104}, 1'b0);
    for (int i = 0; i < 4; i++) begin
      driveCycle('0, '{strobe: 1'b1, ds: 7'(7'o100 + i)}, 1'b0);
    end
    repeat (3) driveCycle('0, '0, 1'b0);
    repeat (200) driveCycle(randomWord(0), '0, 1'b0);
    repeat (200) driveCycle(randomWord(1), '0, 1'b0);
    repeat (150) driveCycle(randomWord(2), '0, $urandom_range(1, 0) == 1);
    repeat (250) driveCycle(randomWord(2), randomReq(), $urandom_range(1, 0) == 1);
    repeat (4) driveCycle('0, '0, 1'b0);
    $display("Run complete with %0d errors", errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/ebox_pkg.sv
hw/ctlDecode.sv
hw/regHalf.sv
hw/diagReadMux.sv
hw/eboxCtlTop.sv
sim/clkGen.sv
sim/eboxCtlTb.sv

// ==== Bender.yml ====
package:
  name: ebox_ctl

sources:
  - include_dirs:
      - hw
    files:
      - hw/ebox_pkg.sv
      - hw/ctlDecode.sv
      - hw/regHalf.sv
      - hw/diagReadMux.sv
      - hw/eboxCtlTop.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/clkGen.sv
      - sim/eboxCtlTb.sv
